// File: Makefile
BIN  = obj_dir/Vburst_fifo_tb
SRCS = $(shell cat src.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): src.f $(SRCS)
	verilator --binary --timing --assert --top-module burst_fifo_tb -f src.f -o Vburst_fifo_tb

# the log decides pass or fail
run: $(BIN) burst_fifo_input.txt
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@if ! grep -q "all tests passed" sim.log; then echo "run ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: burst_fifo.sv
module burst_fifo
   #(parameter int SLOTS_P = burst_fifo_pkg::DEFAULT_SLOTS,
     parameter int MAX_ADD_P = burst_fifo_pkg::LANES,
     localparam int CNT_W = $clog2(SLOTS_P + 1))
   (input  logic                      clk,
    input  logic                      reset_i,
    input  burst_fifo_pkg::push_req_t push_i,
    input  logic [1:0]                pop_count_i,
    output burst_fifo_pkg::pop_resp_t rd_o,
    output logic [CNT_W-1:0]          count_o,
    output logic [CNT_W-1:0]          free_o,
    output logic                      empty_o,
    output logic                      full_o);

   localparam int PTR_W = (SLOTS_P > 1) ? $clog2(SLOTS_P) : 1;
   localparam int ADD_W = $clog2(MAX_ADD_P + 1);

   // per-cycle advances, cut to the width the submodules take
   logic [ADD_W-1:0] push_add;
   logic [ADD_W-1:0] pop_add;

   // current pointers feed the store
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // next-edge pointer values, watched by the bound checks
   logic [PTR_W-1:0] wr_ptr_next;
   logic [PTR_W-1:0] rd_ptr_next;

   assign push_add = push_i.count[ADD_W-1:0];
   assign pop_add  = pop_count_i[ADD_W-1:0];

   // write side advances by the number of words pushed
   fifo_circular_ptr #(.SLOTS_P(SLOTS_P), .MAX_ADD_P(MAX_ADD_P)) u_wr_ptr
      (.clk(clk), .reset_i(reset_i), .add_i(push_add),
       .ptr_o(wr_ptr), .ptr_next_o(wr_ptr_next));

   // read side advances by the number of words popped
   fifo_circular_ptr #(.SLOTS_P(SLOTS_P), .MAX_ADD_P(MAX_ADD_P)) u_rd_ptr
      (.clk(clk), .reset_i(reset_i), .add_i(pop_add),
       .ptr_o(rd_ptr), .ptr_next_o(rd_ptr_next));

   fifo_ring_store
      #(.SLOTS_P(SLOTS_P), .MAX_ADD_P(MAX_ADD_P),
        .payload_type(burst_fifo_pkg::payload_t)) u_store
      (.clk(clk), .reset_i(reset_i), .wr_ptr_i(wr_ptr), .rd_ptr_i(rd_ptr),
       .push_i(push_i), .rd_o(rd_o));

   // fill level and the status flags the user must obey
   fifo_occupancy #(.SLOTS_P(SLOTS_P), .MAX_ADD_P(MAX_ADD_P)) u_occ
      (.clk(clk), .reset_i(reset_i), .push_count_i(push_add), .pop_count_i(pop_add),
       .count_o(count_o), .free_o(free_o), .empty_o(empty_o), .full_o(full_o));

endmodule

// File: burst_fifo_assertions.sv
module burst_fifo_assertions
   #(parameter int SLOTS_P = burst_fifo_pkg::DEFAULT_SLOTS,
     localparam int PTR_W = (SLOTS_P > 1) ? $clog2(SLOTS_P) : 1,
     localparam int CNT_W = $clog2(SLOTS_P + 1))
   (input  logic             clk,
    input  logic             reset_i,
    input  logic [1:0]       push_count_i,
    input  logic [1:0]       pop_count_i,
    input  logic [CNT_W-1:0] count_i,
    input  logic [CNT_W-1:0] free_i,
    input  logic [PTR_W-1:0] wr_ptr_i,
    input  logic [PTR_W-1:0] rd_ptr_i);

   // user must not push more words than there is room for
   a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
                                   int'(push_count_i) <= int'(free_i))
      else $error("push of %0d words with only %0d slots free", push_count_i, free_i);

   // no bypass, so a pop can only take words already stored
   a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
                                    int'(pop_count_i) <= int'(count_i))
      else $error("pop of %0d words with only %0d stored", pop_count_i, count_i);

   // both pointers stay inside the slot range
   a_wr_ptr_range: assert property (@(posedge clk) disable iff (reset_i)
                                    int'(wr_ptr_i) < SLOTS_P)
      else $error("write pointer %0d outside the slot range", wr_ptr_i);

   a_rd_ptr_range: assert property (@(posedge clk) disable iff (reset_i)
                                    int'(rd_ptr_i) < SLOTS_P)
      else $error("read pointer %0d outside the slot range", rd_ptr_i);

endmodule

// File: burst_fifo_input.txt
# columns, hex: push_count word0 word1 pop_count exp_count exp_lane0 exp_lane1
# words are {data, tag}; expected values hold after the rising edge of that cycle
0 00000 00000 0 0 00000 00000
1 a0011 00000 0 1 a0011 00000
1 a0022 00000 0 2 a0011 a0022
1 a0033 00000 0 3 a0011 a0022
0 00000 00000 1 2 a0022 a0033
0 00000 00000 1 1 a0033 00000
0 00000 00000 1 0 00000 00000
2 b0014 b0025 0 2 b0014 b0025
2 b0036 b0047 0 4 b0014 b0025
0 00000 00000 2 2 b0036 b0047
2 b0058 b0069 0 4 b0036 b0047
0 00000 00000 2 2 b0058 b0069
1 c0011 00000 1 2 b0069 c0011
2 c0022 c0033 0 4 b0069 c0011
1 c0044 00000 0 5 b0069 c0011
1 c0055 00000 1 5 c0011 c0022
1 c0066 00000 0 6 c0011 c0022
0 00000 00000 2 4 c0033 c0044
2 d0017 d0028 1 5 c0044 c0055
1 d0039 00000 0 6 c0044 c0055
0 00000 00000 2 4 c0066 d0017
0 00000 00000 2 2 d0028 d0039
0 00000 00000 1 1 d0039 00000
1 d004a 00000 1 1 d004a 00000
2 d005b d006c 1 2 d005b d006c
1 d007d 00000 2 1 d007d 00000
0 00000 00000 1 0 00000 00000
0 00000 00000 0 0 00000 00000
2 e0011 e0022 0 2 e0011 e0022
1 e0033 00000 1 2 e0022 e0033
2 e0044 e0055 0 4 e0022 e0033
0 00000 00000 1 3 e0033 e0044
0 00000 00000 2 1 e0055 00000
0 00000 00000 1 0 00000 00000

// File: burst_fifo_pkg.sv
package burst_fifo_pkg;

   // lanes moved per cycle on each side
   // also the default largest pointer advance
   localparam int LANES = 2;

   // slot count default, not a power of two so the pointers wrap the hard way
   localparam int DEFAULT_SLOTS = 6;

   // one stored word
   typedef struct packed
   {
      // user data
      logic [15:0] data;
      // free-form tag carried along with the data
      logic [3:0]  tag;
   } payload_t;

   // push side of one cycle
   // words[0] is the older of the two words
   typedef struct packed
   {
      // number of valid words, 0 to LANES
      logic [1:0]                count;
      // lanes above count are ignored
      payload_t [LANES-1:0]      words;
   } push_req_t;

   // read side, the oldest entries in order
   // words[0] is the oldest, words[1] the one after it
   typedef struct packed
   {
      // lanes at or above the fill level hold stale data
      payload_t [LANES-1:0]      words;
   } pop_resp_t;

endpackage

// File: burst_fifo_tb.sv
module burst_fifo_tb;

   localparam int SLOTS = burst_fifo_pkg::DEFAULT_SLOTS;
   localparam int CNT_W = $clog2(SLOTS + 1);
   // cycles allowed for the status outputs to settle after reset
   localparam int RESET_TIMEOUT = 20;
   // upper bound on lines read from the stimulus file
   localparam int LINE_LIMIT = 500;

   logic                      clk;
   logic                      reset_i;
   burst_fifo_pkg::push_req_t push_i;
   logic [1:0]                pop_count_i;
   burst_fifo_pkg::pop_resp_t rd_o;
   logic [CNT_W-1:0]          count_o;
   logic [CNT_W-1:0]          free_o;
   logic                      empty_o;
   logic                      full_o;

   burst_fifo #(.SLOTS_P(SLOTS), .MAX_ADD_P(burst_fifo_pkg::LANES)) burst_fifo_inst
      (.clk(clk), .reset_i(reset_i), .push_i(push_i), .pop_count_i(pop_count_i),
       .rd_o(rd_o), .count_o(count_o), .free_o(free_o), .empty_o(empty_o),
       .full_o(full_o));

   // flow-control and pointer checks ride along inside the DUT
   // the range checks see each pointer value one edge before it is taken
   bind burst_fifo burst_fifo_assertions #(.SLOTS_P(SLOTS_P)) u_assertions
      (.clk(clk), .reset_i(reset_i), .push_count_i(push_i.count),
       .pop_count_i(pop_count_i), .count_i(count_o), .free_i(free_o),
       .wr_ptr_i(wr_ptr_next), .rd_ptr_i(rd_ptr_next));

   // 100 time unit period
   always #50 clk = ~clk;

   // stop the run with a plain-words reason
   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("tests failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string       name,
                              input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[FAIL] time %0t %s expected %h actual %h", $time, name, expected, actual);
         $display("tests failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // status flags follow from the fill level alone
   task automatic check_status(input logic [31:0] exp_count);
      check_value("count_o", exp_count, 32'(count_o));
      check_value("free_o", 32'(SLOTS) - exp_count, 32'(free_o));
      check_value("empty_o", 32'(exp_count == 0), 32'(empty_o));
      check_value("full_o", 32'(exp_count == 32'(SLOTS)), 32'(full_o));
   endtask

   initial
   begin
      int          fd;
      int          n;
      int          lines;
      int          reads;
      int          cycles;
      string       line;
      logic [31:0] push_cnt;
      logic [31:0] w0;
      logic [31:0] w1;
      logic [31:0] pop_cnt;
      logic [31:0] exp_cnt;
      logic [31:0] exp_l0;
      logic [31:0] exp_l1;

      clk         = 1'b0;
      reset_i     = 1'b1;
      push_i      = '0;
      pop_count_i = '0;

      // reset held across 8 rising edges
      repeat (8) @(negedge clk);
      reset_i = 1'b0;

      // wait for known status outputs, bounded
      cycles = 0;
      while ($isunknown({count_o, free_o, empty_o, full_o}))
      begin
         if (cycles >= RESET_TIMEOUT)
            fail_run("FIFO status outputs still unknown after reset");
         @(negedge clk);
         cycles++;
      end
      check_status(32'd0);

      fd = $fopen("burst_fifo_input.txt", "r");
      if (fd == 0)
         fail_run("could not open burst_fifo_input.txt");

      lines = 0;
      reads = 0;
      while (!$feof(fd))
      begin
         reads++;
         if (reads > LINE_LIMIT || lines >= LINE_LIMIT)
            fail_run("stimulus file ran past the cycle limit");
         n = $fgets(line, fd);
         // skip comment and blank lines
         if (n <= 0)
            continue;
         if (line.getc(0) == "#" || line.getc(0) == "\n")
            continue;
         n = $sscanf(line, "%h %h %h %h %h %h %h",
                     push_cnt, w0, w1, pop_cnt, exp_cnt, exp_l0, exp_l1);
         if (n != 7)
            fail_run("malformed line in burst_fifo_input.txt");

         // one cycle of stimulus, driven on the falling edge
         push_i.count    = push_cnt[1:0];
         push_i.words[0] = w0[19:0];
         push_i.words[1] = w1[19:0];
         pop_count_i     = pop_cnt[1:0];
         @(posedge clk);
         @(negedge clk);

         check_status(exp_cnt);
         // lanes past the fill level hold stale words
         if (exp_cnt > 0)
            check_value("rd_o.words[0]", exp_l0, 32'(rd_o.words[0]));
         if (exp_cnt > 1)
            check_value("rd_o.words[1]", exp_l1, 32'(rd_o.words[1]));
         lines++;
      end
      $fclose(fd);

      push_i      = '0;
      pop_count_i = '0;

      if (lines == 0)
         fail_run("no stimulus lines found in burst_fifo_input.txt");

      $display("all tests passed");
      $finish;
   end

endmodule

// File: fifo_circular_ptr.sv
module fifo_circular_ptr
   #(parameter int SLOTS_P = burst_fifo_pkg::DEFAULT_SLOTS,
     parameter int MAX_ADD_P = burst_fifo_pkg::LANES,
     localparam int PTR_W = (SLOTS_P > 1) ? $clog2(SLOTS_P) : 1,
     localparam int ADD_W = $clog2(MAX_ADD_P + 1))
   (input  logic             clk,
    input  logic             reset_i,
    input  logic [ADD_W-1:0] add_i,
    output logic [PTR_W-1:0] ptr_o,
    output logic [PTR_W-1:0] ptr_next_o);

   logic [PTR_W-1:0] ptr_r;
   logic [PTR_W-1:0] ptr_n;

   assign ptr_o      = ptr_r;
   assign ptr_next_o = ptr_n;

   always_ff @(posedge clk)
   begin
      if (reset_i)
         ptr_r <= '0;
      else
         ptr_r <= ptr_n;
   end

   if ((SLOTS_P > 1) && ((SLOTS_P & (SLOTS_P - 1)) == 0))
   begin : g_pow2
      // natural wrap of the adder does the modulo
      if (MAX_ADD_P == 1)
      begin : g_inc
         // keep add_i off the adder, it only picks the result
         logic [PTR_W-1:0] ptr_p1;
         assign ptr_p1 = ptr_r + 1'b1;
         assign ptr_n  = add_i[0] ? ptr_p1 : ptr_r;
      end
      else
      begin : g_add
         assign ptr_n = PTR_W'(ptr_r + add_i);
      end
   end
   else
   begin : g_notpow2
      // one extra bit to see the sign of the wrapped sum
      localparam logic [PTR_W:0] SLOTS_W = (PTR_W + 1)'(SLOTS_P);
      logic [PTR_W:0]   ptr_wrap;
      logic [PTR_W-1:0] ptr_nowrap;

      // both candidates in parallel
      assign ptr_wrap   = {1'b0, ptr_r} + (PTR_W + 1)'(add_i) - SLOTS_W;
      assign ptr_nowrap = PTR_W'(ptr_r + add_i);

      // non-negative wrapped sum means we went past the last slot
      assign ptr_n = ptr_wrap[PTR_W] ? ptr_nowrap : ptr_wrap[PTR_W-1:0];
   end

endmodule

// File: fifo_occupancy.sv
module fifo_occupancy
   #(parameter int SLOTS_P = burst_fifo_pkg::DEFAULT_SLOTS,
     parameter int MAX_ADD_P = burst_fifo_pkg::LANES,
     localparam int ADD_W = $clog2(MAX_ADD_P + 1),
     localparam int CNT_W = $clog2(SLOTS_P + 1))
   (input  logic             clk,
    input  logic             reset_i,
    input  logic [ADD_W-1:0] push_count_i,
    input  logic [ADD_W-1:0] pop_count_i,
    output logic [CNT_W-1:0] count_o,
    output logic [CNT_W-1:0] free_o,
    output logic             empty_o,
    output logic             full_o);

   logic [CNT_W-1:0] count_r;
   logic [CNT_W-1:0] count_n;

   // push and pop may land in the same cycle
   // the modulo sum is exact as long as the user respects the status
   assign count_n = count_r + CNT_W'(push_count_i) - CNT_W'(pop_count_i);

   always_ff @(posedge clk)
   begin
      if (reset_i)
         count_r <= '0;
      else
         count_r <= count_n;
   end

   // status all comes off the register
   assign count_o = count_r;
   assign free_o  = CNT_W'(SLOTS_P) - count_r;
   assign empty_o = (count_r == '0);
   assign full_o  = (count_r == CNT_W'(SLOTS_P));

endmodule

// File: fifo_ring_store.sv
module fifo_ring_store
   #(parameter int SLOTS_P = burst_fifo_pkg::DEFAULT_SLOTS,
     parameter int MAX_ADD_P = burst_fifo_pkg::LANES,
     parameter type payload_type = burst_fifo_pkg::payload_t,
     localparam int PTR_W = (SLOTS_P > 1) ? $clog2(SLOTS_P) : 1)
   (input  logic                      clk,
    input  logic                      reset_i,
    input  logic [PTR_W-1:0]          wr_ptr_i,
    input  logic [PTR_W-1:0]          rd_ptr_i,
    input  burst_fifo_pkg::push_req_t push_i,
    output burst_fifo_pkg::pop_resp_t rd_o);

   // storage, no reset needed on the data itself
   payload_type mem [SLOTS_P];

   // slot index for each write lane and each read lane
   logic [PTR_W-1:0] wr_idx [MAX_ADD_P];
   logic [PTR_W-1:0] rd_idx [burst_fifo_pkg::LANES];

   // base plus a small lane offset, folded back into the slot range
   function automatic logic [PTR_W-1:0] wrap_idx(input logic [PTR_W-1:0] base,
                                                 input int unsigned      off);
      logic [PTR_W:0] sum;
      sum = {1'b0, base} + (PTR_W + 1)'(off);
      // offset is below the slot count, one subtract is enough
      if (sum >= (PTR_W + 1)'(SLOTS_P))
         sum = sum - (PTR_W + 1)'(SLOTS_P);
      return sum[PTR_W-1:0];
   endfunction

   always_comb
   begin
      for (int k = 0; k < MAX_ADD_P; k++)
         wr_idx[k] = wrap_idx(wr_ptr_i, k);
      for (int k = 0; k < burst_fifo_pkg::LANES; k++)
         rd_idx[k] = wrap_idx(rd_ptr_i, k);
   end

   // lane k lands k slots after the write pointer
   // only lanes below the push count are written
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < MAX_ADD_P; k++)
      begin
         // nothing lands while the pointers sit in reset
         if (!reset_i && (k < int'(push_i.count)))
            mem[wr_idx[k]] <= payload_type'(push_i.words[k]);
      end
   end

   // oldest entries straight out of the array, no bypass of this cycle's push
   always_comb
   begin
      for (int k = 0; k < burst_fifo_pkg::LANES; k++)
         rd_o.words[k] = mem[rd_idx[k]];
   end

endmodule

// File: src.f
burst_fifo_pkg.sv
fifo_circular_ptr.sv
fifo_ring_store.sv
fifo_occupancy.sv
burst_fifo.sv
burst_fifo_assertions.sv
burst_fifo_tb.sv
